// File: Makefile
TOP := nmea_compressor_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: include/nmea_settings.svh
`ifndef NMEA_SETTINGS_SVH
`define NMEA_SETTINGS_SVH

`define NMEA_SENTENCES   4      // configured sentence types
`define NMEA_MAX_FIELDS  24
`define NMEA_BUF_WORDS   32     // one sentence of 16-bit words
`define NMEA_FMT_ENTRIES 4      // count word plus three flag words

`define NMEA_CH_DOLLAR   8'h24
`define NMEA_CH_G        8'h47
`define NMEA_CH_P        8'h50
`define NMEA_CH_COMMA    8'h2c
`define NMEA_CH_STAR     8'h2a

`endif

// File: list.f
+incdir+include
rtl/nmea_pkg.sv
rtl/nmea_byte_assembler.sv
rtl/nmea_sentence_matcher.sv
rtl/nmea_field_encoder.sv
rtl/nmea_word_buffer.sv
rtl/nmea_compressor_top.sv
tb/nmea_compressor_props.sv
tb/nmea_compressor_tb.sv

// File: rtl/nmea_byte_assembler.sv
`timescale 1ns/1ps

module nmea_byte_assembler (
    input  logic                 xclk,
    input  logic                 ser_rst,
    input  logic                 ser_di,
    input  logic                 ser_stb,
    input  logic                 line_start,
    output nmea_pkg::nmea_byte_t byte_out,
    output logic                 byte_stb
);

    logic [6:0] shift;          // bits 0..6, lsb arrives first
    logic [2:0] bit_cnt;
    logic       first_pend;     // next byte follows a restart
    logic       bit7;

    assign bit7 = ser_stb && !line_start && (bit_cnt == 3'd7);

    always_ff @(posedge xclk) begin
        if (ser_rst) begin
            bit_cnt    <= 3'd0;
            first_pend <= 1'b1;
            byte_stb   <= 1'b0;
        end else begin
            byte_stb <= bit7;
            if (line_start) begin
                bit_cnt    <= 3'd0;
                first_pend <= 1'b1;
            end else if (ser_stb) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit7) begin
                    first_pend <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (ser_stb) begin
            shift <= {ser_di, shift[6:1]};
        end
        if (bit7) begin
            byte_out.data  <= {ser_di, shift};
            byte_out.first <= first_pend;
        end
    end

endmodule

// File: rtl/nmea_compressor_top.sv
`timescale 1ns/1ps

module nmea_compressor_top (
    input  logic                xclk,
    input  logic                ser_rst,
    input  logic                ser_di,
    input  logic                ser_stb,
    input  logic                line_start,
    input  logic                cfg_we,
    input  nmea_pkg::nmea_cfg_t cfg,
    output logic                word_valid,
    input  logic                word_ready,
    output logic [15:0]         word_data,
    output logic                word_last,
    output logic [7:0]          dropped_count
);

    nmea_pkg::nmea_byte_t   byte_bus;
    logic                   byte_stb;
    nmea_pkg::nmea_field_t  field_bus;
    logic                   field_stb;
    nmea_pkg::nmea_nibble_t nib_bus;

    nmea_byte_assembler u_assembler (
        .xclk       (xclk),
        .ser_rst    (ser_rst),
        .ser_di     (ser_di),
        .ser_stb    (ser_stb),
        .line_start (line_start),
        .byte_out   (byte_bus),
        .byte_stb   (byte_stb)
    );

    nmea_sentence_matcher u_matcher (
        .xclk      (xclk),
        .ser_rst   (ser_rst),
        .cfg_we    (cfg_we),
        .cfg       (cfg),
        .byte_in   (byte_bus),
        .byte_stb  (byte_stb),
        .field_out (field_bus),
        .field_stb (field_stb)
    );

    nmea_field_encoder u_encoder (
        .xclk      (xclk),
        .ser_rst   (ser_rst),
        .cfg_we    (cfg_we),
        .cfg       (cfg),
        .field_in  (field_bus),
        .field_stb (field_stb),
        .nib_out   (nib_bus)
    );

    nmea_word_buffer u_buffer (
        .xclk          (xclk),
        .ser_rst       (ser_rst),
        .nib_in        (nib_bus),
        .word_valid    (word_valid),
        .word_ready    (word_ready),
        .word_data     (word_data),
        .word_last     (word_last),
        .dropped_count (dropped_count)
    );

endmodule

// File: rtl/nmea_field_encoder.sv
`timescale 1ns/1ps
`include "nmea_settings.svh"

module nmea_field_encoder (
    input  logic                   xclk,
    input  logic                   ser_rst,
    input  logic                   cfg_we,
    input  nmea_pkg::nmea_cfg_t    cfg,
    input  nmea_pkg::nmea_field_t  field_in,
    input  logic                   field_stb,
    output nmea_pkg::nmea_nibble_t nib_out
);

    nmea_pkg::nmea_fmt_word_u fmt_ram [0:`NMEA_SENTENCES*`NMEA_FMT_ENTRIES-1];
    nmea_pkg::nmea_fmt_word_u cnt_word;
    nmea_pkg::nmea_fmt_word_u flag_word;

    logic       active;
    logic [1:0] sent;
    logic [4:0] field_count;
    logic [4:0] field_idx;        // current field, counted from 1
    logic [4:0] fld0;
    logic [1:0] fmt_entry;
    logic [4:0] head_count;
    logic       first_in_field;
    logic [2:0] held_hi;          // high bits of the previous char
    logic       is_byte;
    logic [7:0] ch;
    logic       sep;
    logic       eos;
    logic       term;
    logic       sent_end;
    logic       pend_valid;
    logic [3:0] pend_nib;
    logic       pend_last;
    logic       set_pend;
    logic [3:0] pend_nib_n;
    logic       pend_last_n;
    logic       emit;
    logic [3:0] emit_nib;
    logic       emit_last;
    logic       nib_valid;
    logic [3:0] nib_val;
    logic       nib_last;

    assign ch         = field_in.data;
    assign sep        = (ch == `NMEA_CH_COMMA);
    assign eos        = (ch == `NMEA_CH_STAR) || (ch[7:4] == 4'h0);
    assign term       = sep || eos;
    assign sent_end   = eos || (sep && (field_idx == field_count));
    assign fld0       = field_idx - 5'd1;
    assign fmt_entry  = fld0[4:3] + 2'd1;
    assign cnt_word   = fmt_ram[{field_in.sent_id, 2'd0}];
    assign flag_word  = fmt_ram[{sent, fmt_entry}];
    assign is_byte    = flag_word.flags.fmt_bits[fld0[2:0]];
    assign head_count = (cnt_word.count.field_count > 5'(`NMEA_MAX_FIELDS)) ?
                        5'(`NMEA_MAX_FIELDS) : cnt_word.count.field_count;
    assign nib_out    = '{nib: nib_val, last: nib_last, valid: nib_valid};

    always_ff @(posedge xclk) begin
        if (cfg_we && cfg.table_sel) begin
            fmt_ram[cfg.addr] <= cfg.data;
        end
    end

    always_comb begin
        emit        = 1'b0;
        emit_nib    = 4'hf;
        emit_last   = 1'b0;
        set_pend    = 1'b0;
        pend_nib_n  = 4'hf;
        pend_last_n = 1'b0;
        if (field_stb && field_in.head) begin
            emit      = 1'b1;
            emit_nib  = {2'b00, field_in.sent_id};
            emit_last = (head_count == 5'd0);
        end else if (field_stb && active) begin
            emit = 1'b1;
            if (!is_byte) begin
                emit_nib  = term ? 4'hf : ch[3:0];
                emit_last = term && sent_end;
            end else if (first_in_field) begin
                if (term) begin              // empty byte field, two f nibbles
                    set_pend    = 1'b1;
                    pend_last_n = sent_end;
                end else begin
                    emit_nib = ch[3:0];
                end
            end else begin
                emit_nib = {term, held_hi};  // bit 3 marks the field's last char
                if (term) begin
                    emit_last = sent_end;
                end else begin
                    set_pend   = 1'b1;
                    pend_nib_n = ch[3:0];
                end
            end
        end else if (pend_valid) begin
            emit      = 1'b1;
            emit_nib  = pend_nib;
            emit_last = pend_last;
        end
    end

    always_ff @(posedge xclk) begin
        if (ser_rst) begin
            active     <= 1'b0;
            pend_valid <= 1'b0;
            nib_valid  <= 1'b0;
        end else begin
            nib_valid  <= emit;
            pend_valid <= set_pend;
            if (field_stb && field_in.head) begin
                active <= (head_count != 5'd0);
            end else if (field_stb && active && term && sent_end) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (emit) begin
            nib_val  <= emit_nib;
            nib_last <= emit_last;
        end
        if (set_pend) begin
            pend_nib  <= pend_nib_n;
            pend_last <= pend_last_n;
        end
        if (field_stb && field_in.head) begin
            sent           <= field_in.sent_id;
            field_count    <= head_count;
            field_idx      <= 5'd1;
            first_in_field <= 1'b1;
        end else if (field_stb && active) begin
            held_hi        <= ch[6:4];
            first_in_field <= term;
            if (sep) begin
                field_idx <= field_idx + 5'd1;
            end
        end
    end

endmodule

// File: rtl/nmea_pkg.sv
package nmea_pkg;

    typedef struct packed {
        logic [7:0] data;
        logic       first;       // first byte after line_start
    } nmea_byte_t;

    typedef struct packed {
        logic [7:0] data;
        logic [1:0] sent_id;
        logic       head;        // sentence head beat, data unused
    } nmea_field_t;

    typedef struct packed {
        logic [2:0] reserved;
        logic [4:0] field_count;
    } nmea_fmt_count_t;

    typedef struct packed {
        logic [7:0] fmt_bits;    // 1 = byte field, lsb is the lowest field
    } nmea_fmt_flags_t;

    // entry 0 holds the count, entries 1..3 the per-field flags
    typedef union packed {
        nmea_fmt_count_t count;
        nmea_fmt_flags_t flags;
    } nmea_fmt_word_u;

    typedef struct packed {
        logic       table_sel;   // 0 names, 1 formats
        logic [3:0] addr;
        logic [7:0] data;
    } nmea_cfg_t;

    typedef struct packed {
        logic [3:0] nib;
        logic       last;
        logic       valid;
    } nmea_nibble_t;

endpackage

// File: rtl/nmea_sentence_matcher.sv
`timescale 1ns/1ps
`include "nmea_settings.svh"

module nmea_sentence_matcher (
    input  logic                  xclk,
    input  logic                  ser_rst,
    input  logic                  cfg_we,
    input  nmea_pkg::nmea_cfg_t   cfg,
    input  nmea_pkg::nmea_byte_t  byte_in,
    input  logic                  byte_stb,
    output nmea_pkg::nmea_field_t field_out,
    output logic                  field_stb
);

    typedef enum logic [2:0] {
        S_IDLE, S_G, S_P, S_L0, S_L1, S_L2, S_COMMA, S_FIELDS
    } state_t;

    state_t     state;
    logic [3:0] cand;           // types still matching the letters
    logic [7:0] name_ram [0:4*`NMEA_SENTENCES-1];
    logic [7:0] ch;
    logic [1:0] letter;
    logic [3:0] hit;
    logic [1:0] lowest;
    logic       restart;
    logic       is_end;

    assign ch      = byte_in.data;
    assign restart = byte_in.first || (ch == `NMEA_CH_DOLLAR);
    assign is_end  = (ch == `NMEA_CH_STAR) || (ch[7:4] == 4'h0);

    always_ff @(posedge xclk) begin
        if (cfg_we && !cfg.table_sel) begin
            name_ram[cfg.addr] <= cfg.data;
        end
    end

    always_comb begin
        case (state)
            S_L1:    letter = 2'd1;
            S_L2:    letter = 2'd2;
            default: letter = 2'd0;
        endcase
        for (int s = 0; s < `NMEA_SENTENCES; s++) begin
            hit[s] = (name_ram[s * 4 + letter] == ch);
        end
        if (cand[0])      lowest = 2'd0;
        else if (cand[1]) lowest = 2'd1;
        else if (cand[2]) lowest = 2'd2;
        else              lowest = 2'd3;
    end

    always_ff @(posedge xclk) begin
        if (ser_rst) begin
            state     <= S_IDLE;
            cand      <= 4'h0;
            field_stb <= 1'b0;
        end else begin
            field_stb <= 1'b0;
            if (byte_stb) begin
                if (restart) begin
                    field_stb <= (state == S_FIELDS);   // close an interrupted sentence
                    state     <= (ch == `NMEA_CH_DOLLAR) ? S_G : S_IDLE;
                end else begin
                    case (state)
                        S_G: state <= (ch == `NMEA_CH_G) ? S_P : S_IDLE;
                        S_P: begin
                            state <= (ch == `NMEA_CH_P) ? S_L0 : S_IDLE;
                            cand  <= 4'hf;
                        end
                        S_L0, S_L1, S_L2: begin
                            cand  <= cand & hit;
                            state <= state_t'(state + 3'd1);
                        end
                        S_COMMA: begin
                            if ((ch == `NMEA_CH_COMMA) && (cand != 4'h0)) begin
                                state     <= S_FIELDS;
                                field_stb <= 1'b1;     // head beat
                            end else begin
                                state <= S_IDLE;
                            end
                        end
                        S_FIELDS: begin
                            field_stb <= 1'b1;
                            if (is_end) begin
                                state <= S_IDLE;
                            end
                        end
                        default: state <= S_IDLE;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (byte_stb) begin
            field_out.data <= restart ? 8'h00 : ch;     // forced line end on restart
            field_out.head <= (state == S_COMMA);
            if (state == S_COMMA) begin
                field_out.sent_id <= lowest;
            end
        end
    end

endmodule

// File: rtl/nmea_word_buffer.sv
`timescale 1ns/1ps
`include "nmea_settings.svh"

module nmea_word_buffer (
    input  logic                   xclk,
    input  logic                   ser_rst,
    input  nmea_pkg::nmea_nibble_t nib_in,
    output logic                   word_valid,
    input  logic                   word_ready,
    output logic [15:0]            word_data,
    output logic                   word_last,
    output logic [7:0]             dropped_count
);

    logic [15:0] mem [0:`NMEA_BUF_WORDS-1];
    logic [15:0] acc;             // word under assembly
    logic [15:0] wword;
    logic [1:0]  lane;
    logic [5:0]  wr_cnt;
    logic [4:0]  rd_ptr;
    logic [4:0]  last_idx;
    logic        held;            // complete sentence waiting for the host
    logic        in_sent;
    logic        dropping;
    logic        drop_now;
    logic        wr_ok;
    logic        wr_full;
    logic        rd_fire;

    assign drop_now   = in_sent ? dropping : held;  // decided on the first nibble
    assign wr_ok      = nib_in.valid && !drop_now;
    assign wr_full    = (wr_cnt == 6'(`NMEA_BUF_WORDS));
    assign rd_fire    = word_valid && word_ready;
    assign word_valid = held;
    assign word_data  = mem[rd_ptr];
    assign word_last  = (rd_ptr == last_idx);

    always_comb begin
        wword = acc;
        wword[lane * 4 +: 4] = nib_in.nib;
        if (nib_in.last) begin
            for (int i = 1; i < 4; i++) begin
                if (i > lane) begin
                    wword[i * 4 +: 4] = 4'hf;   // pad the partial word
                end
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (wr_ok && !wr_full && ((lane == 2'd3) || nib_in.last)) begin
            mem[wr_cnt[4:0]] <= wword;
        end
        if (wr_ok) begin
            acc <= wword;
        end
        if (wr_ok && nib_in.last) begin
            last_idx <= wr_full ? 5'(`NMEA_BUF_WORDS - 1) : wr_cnt[4:0];
        end
    end

    always_ff @(posedge xclk) begin
        if (ser_rst) begin
            lane          <= 2'd0;
            wr_cnt        <= 6'd0;
            rd_ptr        <= 5'd0;
            held          <= 1'b0;
            in_sent       <= 1'b0;
            dropping      <= 1'b0;
            dropped_count <= 8'd0;
        end else begin
            if (nib_in.valid) begin
                in_sent <= !nib_in.last;
                if (!in_sent) begin
                    dropping <= held;
                end
            end
            if (wr_ok) begin
                if (nib_in.last) begin
                    lane   <= 2'd0;
                    wr_cnt <= 6'd0;
                    held   <= 1'b1;
                end else begin
                    lane <= lane + 2'd1;
                    if ((lane == 2'd3) && !wr_full) begin
                        wr_cnt <= wr_cnt + 6'd1;
                    end
                end
            end
            if (nib_in.valid && nib_in.last && drop_now && (dropped_count != 8'hff)) begin
                dropped_count <= dropped_count + 8'd1;
            end
            if (rd_fire) begin
                rd_ptr <= word_last ? 5'd0 : rd_ptr + 5'd1;
                if (word_last) begin
                    held <= 1'b0;
                end
            end
        end
    end

endmodule

// File: tb/nmea_compressor_props.sv
`timescale 1ns/1ps

module nmea_compressor_props (
    input logic        xclk,
    input logic        ser_rst,
    input logic        word_valid,
    input logic        word_ready,
    input logic [15:0] word_data,
    input logic        word_last,
    input logic [7:0]  dropped_count
);

    // checked one cycle on, the register is cleared by the reset edge
    valid_low_in_reset: assert property (
        @(posedge xclk) ser_rst |=> !word_valid
    ) else $error("word_valid high during reset");

    stable_under_stall: assert property (
        @(posedge xclk) disable iff (ser_rst)
        (word_valid && !word_ready) |=>
            (word_valid && $stable(word_data) && $stable(word_last))
    ) else $error("read port changed while stalled");

    drops_never_fall: assert property (
        @(posedge xclk) disable iff (ser_rst)
        1'b1 |=> (dropped_count >= $past(dropped_count))
    ) else $error("dropped_count decreased outside reset");

endmodule

// File: tb/nmea_compressor_tb.sv
`timescale 1ns/1ps
`include "nmea_settings.svh"

module nmea_compressor_tb;

    localparam int N_ENTRIES = 11;

    logic                xclk;
    logic                ser_rst;
    logic                ser_di;
    logic                ser_stb;
    logic                line_start;
    logic                cfg_we;
    nmea_pkg::nmea_cfg_t cfg;
    logic                word_valid;
    logic                word_ready;
    logic [15:0]         word_data;
    logic                word_last;
    logic [7:0]          dropped_count;

    logic [23:0] type_name [`NMEA_SENTENCES];
    logic [23:0] fmt_mask  [`NMEA_SENTENCES];     // 1 marks a byte field and the lsb is field 1
    int          field_cnt [`NMEA_SENTENCES];
    string       tab_str   [N_ENTRIES];
    int          tab_out   [N_ENTRIES];           // expected to produce words
    int          tab_hold  [N_ENTRIES];           // host skips reading for one entry
    int          tab_junk  [N_ENTRIES];           // stray bits before line_start
    logic [15:0] exp_words  [$];
    logic [15:0] held_words [$];                  // sentence waiting in the DUT
    int          errors      = 0;
    int          checks      = 0;
    int          exp_drops   = 0;
    int          cycles      = 0;
    int          cycle_limit = 1000000;

    nmea_compressor_top i_nmea_compressor_top (
        .xclk          (xclk),
        .ser_rst       (ser_rst),
        .ser_di        (ser_di),
        .ser_stb       (ser_stb),
        .line_start    (line_start),
        .cfg_we        (cfg_we),
        .cfg           (cfg),
        .word_valid    (word_valid),
        .word_ready    (word_ready),
        .word_data     (word_data),
        .word_last     (word_last),
        .dropped_count (dropped_count)
    );

    bind nmea_word_buffer nmea_compressor_props i_props (
        .xclk          (xclk),
        .ser_rst       (ser_rst),
        .word_valid    (word_valid),
        .word_ready    (word_ready),
        .word_data     (word_data),
        .word_last     (word_last),
        .dropped_count (dropped_count)
    );

    always #2 xclk = ~xclk;

    always @(posedge xclk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // expected words of a sentence whose header is known to be valid
    function automatic void encode_sentence(input string s);
        logic [3:0]  nibs [$];
        logic [7:0]  ch;
        logic [15:0] w;
        int          id;
        int          fld;
        bit          empty;
        bit          done;
        bit          term;
        bit          eos;
        exp_words.delete();
        id = 0;
        for (int t = 0; t < `NMEA_SENTENCES; t++) begin
            if ({s[3], s[4], s[5]} == type_name[t]) begin
                id = t;
            end
        end
        nibs.push_back(4'(id));
        fld   = 1;
        empty = 1'b1;
        done  = (field_cnt[id] == 0);
        for (int k = 7; k < s.len() && !done; k++) begin
            ch   = s[k];
            term = (ch == `NMEA_CH_COMMA);
            eos  = (ch == `NMEA_CH_STAR) || (ch < 8'h10);
            if (term || eos) begin
                if (!fmt_mask[id][fld - 1]) begin
                    nibs.push_back(4'hf);
                end else if (empty) begin
                    nibs.push_back(4'hf);         // empty byte field
                    nibs.push_back(4'hf);
                end else begin
                    nibs[nibs.size() - 1] = nibs[nibs.size() - 1] | 4'h8;
                end
                done  = eos || (fld == field_cnt[id]);
                fld   = fld + 1;
                empty = 1'b1;
            end else begin
                nibs.push_back(ch[3:0]);
                if (fmt_mask[id][fld - 1]) begin
                    nibs.push_back(ch[7:4]);
                end
                empty = 1'b0;
            end
        end
        for (int i = 0; i < nibs.size(); i += 4) begin
            w = 16'hffff;                         // pad nibbles stay f
            for (int j = 0; j < 4; j++) begin
                if (i + j < nibs.size()) begin
                    w[j * 4 +: 4] = nibs[i + j];
                end
            end
            exp_words.push_back(w);
        end
    endfunction

    task automatic write_cfg(input logic sel, input int addr, input logic [7:0] data);
        cfg.table_sel = sel;
        cfg.addr      = 4'(addr);
        cfg.data      = data;
        cfg_we        = 1'b1;
        @(negedge xclk);
        cfg_we = 1'b0;
    endtask

    task automatic send_bit(input logic b);
        ser_di  = b;
        ser_stb = 1'b1;
        @(negedge xclk);
        ser_stb = 1'b0;
        repeat (3) @(negedge xclk);               // one strobe every 4 cycles
    endtask

    task automatic send_sentence(input string s, input int junk);
        logic [7:0] ch;
        for (int j = 0; j < junk; j++) begin
            send_bit(1'($urandom));
        end
        line_start = 1'b1;
        @(negedge xclk);
        line_start = 1'b0;
        for (int k = 0; k < s.len(); k++) begin
            ch = s[k];
            for (int b = 0; b < 8; b++) begin
                send_bit(ch[b]);                  // lsb first
            end
        end
        repeat (8) @(negedge xclk);               // pipeline drains within a few cycles
    endtask

    task automatic read_held();
        int gap;
        for (int w = 0; w < held_words.size(); w++) begin
            gap = int'($urandom % 4);
            repeat (gap) @(negedge xclk);         // host stall
            while (!word_valid) begin
                @(negedge xclk);
            end
            checks = checks + 2;
            assert (word_data === held_words[w]) else begin
                errors++;
                $display("FAILED %0t word_data expected %h actual %h",
                         $time, held_words[w], word_data);
            end
            assert (word_last === (w == held_words.size() - 1)) else begin
                errors++;
                $display("FAILED %0t word_last expected %b actual %b",
                         $time, (w == held_words.size() - 1), word_last);
            end
            word_ready = 1'b1;
            @(negedge xclk);
            word_ready = 1'b0;
        end
        checks++;
        assert (!word_valid) else begin
            errors++;
            $display("FAILED %0t word_valid expected 0 actual %b after the last word",
                     $time, word_valid);
        end
        held_words.delete();
    endtask

    initial begin
        void'($urandom(32'h2934_af97));
        xclk       = 1'b0;
        ser_rst    = 1'b1;
        ser_di     = 1'b0;
        ser_stb    = 1'b0;
        line_start = 1'b0;
        cfg_we     = 1'b0;
        cfg        = '0;
        word_ready = 1'b0;

        type_name = '{"GGA", "RMC", "GSA", "VTG"};
        fmt_mask  = '{24'h000014, 24'h00012a, 24'h000001, 24'h00000a};
        field_cnt = '{6, 9, 5, 7};
        tab_str = '{
            "$GPGGA,123519,4807.038,N,01131.000,E,1,08,0.9*47\n",
            "$GPRMC,081836,A,3751.65,S,14507.36,E,000.0,360.0,130998,,011.3,E*62\n",
            "$GPGSA,,3,04,05,,09*1D\n",
            "$GPVTG,054.7,T,034.4,M*48\n",
            "$GNGGA,1,2*00\n",                    // bad prefix
            "$GPXYZ,1,2*00\n$GP",                 // unknown type and a cut header
            "GGA,123,4*00\n",                     // joined mid-sentence
            "$GPGSA,A,3,1\n",                     // line end before field count
            "$GPVTG,1.5,T,,M,2.0,N,3.7,K*00\n",
            "$GPGGA,1,2,S,3,W,4*00\n",            // lost while the previous one is unread
            "$GPRMC,1,V,2,N,3,W,4,5,,*00\n"
        };
        tab_out  = '{1, 1, 1, 1, 0, 0, 0, 1, 1, 1, 1};
        tab_hold = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0};
        tab_junk = '{0, 3, 0, 0, 0, 0, 5, 0, 0, 0, 2};

        cycle_limit = 2000;
        for (int i = 0; i < N_ENTRIES; i++) begin
            cycle_limit = cycle_limit + (tab_str[i].len() + tab_junk[i]) * 40;
        end

        repeat (3) @(negedge xclk);
        ser_rst = 1'b0;

        for (int t = 0; t < `NMEA_SENTENCES; t++) begin
            for (int l = 0; l < 3; l++) begin
                write_cfg(1'b0, t * 4 + l, type_name[t][23 - 8 * l -: 8]);
            end
            write_cfg(1'b1, t * `NMEA_FMT_ENTRIES, 8'(field_cnt[t]));
            for (int e = 1; e < `NMEA_FMT_ENTRIES; e++) begin
                write_cfg(1'b1, t * `NMEA_FMT_ENTRIES + e, fmt_mask[t][8 * (e - 1) +: 8]);
            end
        end

        for (int i = 0; i < N_ENTRIES; i++) begin
            send_sentence(tab_str[i], tab_junk[i]);
            if (tab_out[i] != 0) begin
                encode_sentence(tab_str[i]);
                if (held_words.size() != 0) begin
                    exp_drops++;                  // buffer still full
                end else begin
                    held_words = exp_words;
                end
            end
            checks++;
            assert (dropped_count === 8'(exp_drops)) else begin
                errors++;
                $display("FAILED %0t dropped_count expected %0d actual %0d",
                         $time, exp_drops, dropped_count);
            end
            if (held_words.size() == 0) begin
                checks++;
                assert (!word_valid) else begin
                    errors++;
                    $display("FAILED %0t word_valid expected 0 actual %b for entry %0d",
                             $time, word_valid, i);
                end
            end else if (tab_hold[i] == 0) begin
                read_held();
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
